//--- Bender.yml
package:
  name: dp_datapath

export_include_dirs:
  - .

sources:
  - dp_pkg.sv
  - regfile.sv
  - imm_ext.sv
  - alu32.sv
  - phase_ctrl.sv
  - dp_top.sv
  - target: test
    files:
      - dp_properties.sv
      - dp_checker.sv
      - dp_tb.sv

//--- alu32.sv
`timescale 1ns/10ps
`include "dp_defs.svh"

module alu32 (
  input  dp_pkg::word_t       src1,
  input  dp_pkg::word_t       src2,
  input  dp_pkg::opcode_t     opcode,
  input  dp_pkg::sub_opcode_t sub_opcode,
  output dp_pkg::word_t       result,
  output logic                overflow
);

  localparam int W   = `DP_DATA_W;
  localparam int MSB = W - 1;

  dp_pkg::word_t     sum;
  dp_pkg::word_t     diff;
  logic              ovf_add;
  logic              ovf_sub;
  logic [4:0]        shamt;
  logic [2*W-1:0]    rot_pair;
  logic              is_alu;

  assign sum  = src1 + src2;
  assign diff = src1 - src2;

  // signed overflow, operand signs vs result sign
  assign ovf_add = (src1[MSB] == src2[MSB]) && (sum[MSB] != src1[MSB]);
  assign ovf_sub = (src1[MSB] != src2[MSB]) && (diff[MSB] != src1[MSB]);

  assign shamt    = src2[4:0];
  assign rot_pair = {src1, src1} >> shamt; // low half is the rotate

  assign is_alu = (opcode == `OP_ALU) || (opcode == `OP_ALU_IMM);

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    if (is_alu) begin
      case (sub_opcode)
        `SUB_ADD: begin
          result   = sum;
          overflow = ovf_add;
        end
        `SUB_SUB: begin
          result   = diff;
          overflow = ovf_sub;
        end
        `SUB_AND: begin
          result = src1 & src2;
        end
        `SUB_OR: begin
          result = src1 | src2;
        end
        `SUB_XOR: begin
          result = src1 ^ src2;
        end
        `SUB_SLLI: begin
          result = src1 << shamt;
        end
        `SUB_SRLI: begin
          result = src1 >> shamt; // logical
        end
        `SUB_ROTRI: begin
          result = rot_pair[W-1:0];
        end
        default: begin
          result = '0;
        end
      endcase
    end
  end

endmodule

//--- compile.f
+incdir+.
dp_pkg.sv
regfile.sv
imm_ext.sv
alu32.sv
phase_ctrl.sv
dp_top.sv
dp_properties.sv
dp_checker.sv
dp_tb.sv

//--- dp_checker.sv
`timescale 1ns/10ps
`include "dp_defs.svh"

module dp_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ack,
  input  dp_pkg::reg_addr_t   raddr1,
  input  dp_pkg::reg_addr_t   raddr2,
  input  dp_pkg::reg_addr_t   waddr,
  input  logic         [4:0]  imm5,
  input  logic         [14:0] imm15,
  input  logic         [19:0] imm20,
  input  dp_pkg::imm_fmt_t    imm_fmt,
  input  logic                imm_sel,
  input  logic                wb_sel,
  input  dp_pkg::opcode_t     opcode,
  input  dp_pkg::sub_opcode_t sub_opcode,
  input  logic                exp_ovf,
  input  dp_pkg::word_t       result,
  input  logic                overflow,
  output int                  n_pass,
  output int                  n_fail
);

  dp_pkg::word_t model [32];
  logic          ack_d;

  function automatic dp_pkg::word_t extend(input logic [1:0] fmt);
    case (fmt)
      `IMM_ZE5:  return {27'd0, imm5};
      `IMM_SE15: return {{17{imm15[14]}}, imm15};
      `IMM_ZE15: return {17'd0, imm15};
      default:   return {{12{imm20[19]}}, imm20};
    endcase
  endfunction

  function automatic dp_pkg::word_t alu_model(input dp_pkg::word_t a, input dp_pkg::word_t b);
    int s;
    s = b[4:0];
    if (opcode != `OP_ALU && opcode != `OP_ALU_IMM) return '0;
    case (sub_opcode)
      `SUB_ADD:   return a + b;
      `SUB_SUB:   return a - b;
      `SUB_AND:   return a & b;
      `SUB_OR:    return a | b;
      `SUB_XOR:   return a ^ b;
      `SUB_SLLI:  return a << s;
      `SUB_SRLI:  return a >> s;
      `SUB_ROTRI: return (s == 0) ? a : ((a >> s) | (a << (32 - s)));
      default:    return '0;
    endcase
  endfunction

  task automatic check_result();
    dp_pkg::word_t a;
    dp_pkg::word_t b;
    dp_pkg::word_t exp;
    a = model[raddr1];
    b = imm_sel ? extend(imm_fmt) : model[raddr2];
    exp = wb_sel ? b : alu_model(a, b);
    model[waddr] = exp;
    if (result !== exp || overflow !== exp_ovf) begin
      $display("Fail at %0t: test %0d got %h ovf %b, expected %h ovf %b",
               $time, n_pass + n_fail + 1, result, overflow, exp, exp_ovf);
      n_fail++;
    end else begin
      $display("test %0d ok: r%0d = %h ovf %b", n_pass + n_fail + 1, waddr, exp, overflow);
      n_pass++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      foreach (model[i]) model[i] = '0;
      ack_d <= 1'b0;
      n_pass = 0;
      n_fail = 0;
    end else begin
      if (ack && !ack_d) check_result(); // fields still held from the driver
      ack_d <= ack;
    end
  end

endmodule

//--- dp_defs.svh
`ifndef DP_DEFS_SVH
`define DP_DEFS_SVH

`define DP_DATA_W 32
`define DP_ADDR_W 5

// major opcodes
`define OP_ALU     6'b100000
`define OP_ALU_IMM 6'b100001

// sub-opcodes
`define SUB_ADD   5'b00000
`define SUB_SUB   5'b00001
`define SUB_AND   5'b00010
`define SUB_XOR   5'b00011
`define SUB_OR    5'b00100
`define SUB_SLLI  5'b01000
`define SUB_SRLI  5'b01001
`define SUB_ROTRI 5'b01011

// immediate formats
`define IMM_ZE5  2'b00
`define IMM_SE15 2'b01
`define IMM_ZE15 2'b10
`define IMM_SE20 2'b11

`endif

//--- dp_pkg.sv
`include "dp_defs.svh"

package dp_pkg;

  typedef logic [`DP_DATA_W-1:0] word_t;
  typedef logic [`DP_ADDR_W-1:0] reg_addr_t;

  typedef logic [5:0] opcode_t;
  typedef logic [4:0] sub_opcode_t;

  typedef logic [1:0] imm_fmt_t;

  // sequencer phases, one operation at a time
  typedef enum logic [2:0] {
    PH_IDLE  = 3'd0,
    PH_FETCH = 3'd1,
    PH_EXEC  = 3'd2,
    PH_WB    = 3'd3,
    PH_DONE  = 3'd4
  } phase_t;

endpackage

//--- dp_properties.sv
`timescale 1ns/10ps

module dp_properties (
  input logic          clk,
  input logic          rst_n,
  input logic          req,
  input logic          ack,
  input dp_pkg::word_t result
);

  int err_cnt = 0;

  // ack is registered, so it is first sampled high on the fifth edge
  ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(req) |-> ##5 $rose(ack))
    else begin
      $error("ack did not rise 4 edges after req was sampled");
      err_cnt++;
    end

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> $past(req))
    else begin
      $error("ack rose without a pending req");
      err_cnt++;
    end

  req_waits_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(req) |-> ack)
    else begin
      $error("req dropped before ack");
      err_cnt++;
    end

  result_held: assert property (@(posedge clk) disable iff (!rst_n)
      ack |-> $stable(result))
    else begin
      $error("result changed while ack was high");
      err_cnt++;
    end

endmodule

bind dp_top dp_properties u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .ack    (ack),
  .result (result)
);

//--- dp_tb.sv
`timescale 1ns/10ps
`include "dp_defs.svh"

module dp_tb;

  typedef struct packed {
    logic [4:0]  sub;
    logic [4:0]  ra1;
    logic [4:0]  ra2;
    logic [4:0]  wa;
    logic [19:0] val;  // imm5 and imm15 take its low bits
    logic [1:0]  fmt;
    logic        isel;
    logic        wsel;
    logic        ovf;
    logic [2:0]  hold; // extra cycles req stays up after ack
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                req;
  dp_pkg::reg_addr_t   raddr1;
  dp_pkg::reg_addr_t   raddr2;
  dp_pkg::reg_addr_t   waddr;
  logic         [4:0]  imm5;
  logic         [14:0] imm15;
  logic         [19:0] imm20;
  dp_pkg::imm_fmt_t    imm_fmt;
  logic                imm_sel;
  logic                wb_sel;
  dp_pkg::opcode_t     opcode;
  dp_pkg::sub_opcode_t sub_opcode;
  logic                exp_ovf;
  logic                ack;
  dp_pkg::word_t       result;
  logic                overflow;
  int                  n_pass;
  int                  n_fail;

  row_t        rows [$];
  logic [15:0] lfsr_q = 16'd38;
  int          hs_err = 0;
  int          cycles = 0;
  int          limit = 0;

  dp_top dut (.*);
  dp_checker u_check (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [19:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[18:0], lfsr_q[0]};
    end
  endtask

  task automatic add_row(input logic [4:0] sub, wa, ra1, ra2, input logic isel, wsel,
                         input logic [1:0] fmt, input logic [19:0] val, input logic ovf,
                         input logic [2:0] hold);
    row_t r;
    r = {sub, ra1, ra2, wa, val, fmt, isel, wsel, ovf, hold};
    rows.push_back(r);
  endtask

  task automatic movi(input logic [4:0] wa, input logic [1:0] fmt, input logic [19:0] val);
    add_row(`SUB_ADD, wa, 5'd0, 5'd0, 1'b1, 1'b1, fmt, val, 1'b0, 3'd0);
  endtask

  task automatic op_rr(input logic [4:0] sub, wa, ra1, ra2, input logic ovf);
    add_row(sub, wa, ra1, ra2, 1'b0, 1'b0, 2'd0, 20'd0, ovf, 3'd0);
  endtask

  task automatic op_ri(input logic [4:0] sub, wa, ra1, input logic [1:0] fmt,
                       input logic [19:0] val);
    add_row(sub, wa, ra1, 5'd0, 1'b1, 1'b0, fmt, val, 1'b0, 3'd0);
  endtask

  task automatic build_table();
    logic [19:0] v;
    op_rr(`SUB_ADD, 5'd3, 5'd1, 5'd2, 1'b0); // registers untouched since reset
    movi(5'd1, `IMM_ZE5, 20'h0001f);
    movi(5'd2, `IMM_SE15, 20'h04000);
    movi(5'd3, `IMM_ZE15, 20'h04000);
    movi(5'd4, `IMM_SE20, 20'h80001);
    op_rr(`SUB_ADD, 5'd5, 5'd2, 5'd0, 1'b0);
    op_rr(`SUB_ADD, 5'd6, 5'd4, 5'd0, 1'b0);
    op_rr(`SUB_ADD, 5'd1, 5'd1, 5'd0, 1'b0);
    op_rr(`SUB_ADD, 5'd3, 5'd3, 5'd0, 1'b0);
    movi(5'd7, `IMM_SE20, 20'h7ffff);
    op_ri(`SUB_SLLI, 5'd7, 5'd7, `IMM_ZE5, 20'd12);
    op_ri(`SUB_OR, 5'd7, 5'd7, `IMM_ZE15, 20'h00fff); // r7 = 7fffffff
    movi(5'd8, `IMM_ZE5, 20'd1);
    op_rr(`SUB_ADD, 5'd9, 5'd7, 5'd8, 1'b1);  // max + 1
    op_rr(`SUB_SUB, 5'd10, 5'd9, 5'd8, 1'b1); // min - 1
    op_rr(`SUB_ADD, 5'd11, 5'd9, 5'd9, 1'b1);
    op_rr(`SUB_SUB, 5'd12, 5'd8, 5'd8, 1'b0);
    op_rr(`SUB_ADD, 5'd13, 5'd7, 5'd2, 1'b0); // mixed signs
    op_rr(`SUB_ADD, 5'd12, 5'd9, 5'd2, 1'b1);
    op_rr(`SUB_SUB, 5'd14, 5'd0, 5'd9, 1'b1);
    op_rr(`SUB_SUB, 5'd10, 5'd2, 5'd7, 1'b1);
    for (int i = 16; i < 20; i++) begin
      rand_bits(20, v);
      movi(5'(i), `IMM_SE20, v);
    end
    op_rr(`SUB_AND, 5'd20, 5'd16, 5'd17, 1'b0);
    op_rr(`SUB_OR, 5'd21, 5'd18, 5'd19, 1'b0);
    op_rr(`SUB_XOR, 5'd22, 5'd16, 5'd19, 1'b0);
    op_ri(`SUB_SLLI, 5'd23, 5'd16, `IMM_ZE5, 20'd0);
    op_ri(`SUB_SLLI, 5'd24, 5'd17, `IMM_ZE5, 20'd31);
    op_ri(`SUB_SRLI, 5'd25, 5'd4, `IMM_ZE5, 20'd31);
    op_ri(`SUB_SRLI, 5'd26, 5'd18, `IMM_ZE5, 20'd0);
    op_ri(`SUB_SRLI, 5'd27, 5'd9, `IMM_ZE5, 20'd4);
    op_ri(`SUB_ROTRI, 5'd28, 5'd4, `IMM_ZE5, 20'd31);
    op_ri(`SUB_ROTRI, 5'd29, 5'd4, `IMM_ZE5, 20'd0);
    op_ri(`SUB_ROTRI, 5'd30, 5'd16, `IMM_ZE5, 20'd7);
    op_ri(`SUB_SLLI, 5'd31, 5'd19, `IMM_ZE5, 20'd13);
    movi(5'd15, `IMM_ZE5, 20'd5);
    add_row(`SUB_ADD, 5'd15, 5'd15, 5'd8, 1'b0, 1'b0, 2'd0, 20'd0, 1'b0, 3'd4);
    op_rr(`SUB_ADD, 5'd15, 5'd15, 5'd0, 1'b0); // 6 only if the held op ran once
  endtask

  task automatic run_row(input row_t r);
    int edges;
    raddr1 = r.ra1;
    raddr2 = r.ra2;
    waddr = r.wa;
    imm5 = r.val[4:0];
    imm15 = r.val[14:0];
    imm20 = r.val;
    imm_fmt = r.fmt;
    imm_sel = r.isel;
    wb_sel = r.wsel;
    opcode = r.isel ? `OP_ALU_IMM : `OP_ALU;
    sub_opcode = r.sub;
    exp_ovf = r.ovf;
    req = 1'b1;
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack);
    if (edges != 5) begin // ack 4 edges after the edge that samples req
      $display("Fail at %0t: ack came %0d edges after req, expected 5", $time, edges);
      hs_err++;
    end
    repeat (r.hold) begin
      @(posedge clk);
      #1;
      if (!ack) begin
        $display("ack dropped at %0t while req was still held high", $time);
        hs_err++;
      end
    end
    req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (ack);
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    raddr1 = '0;
    raddr2 = '0;
    waddr = '0;
    imm5 = '0;
    imm15 = '0;
    imm20 = '0;
    imm_fmt = '0;
    imm_sel = 1'b0;
    wb_sel = 1'b0;
    opcode = '0;
    sub_opcode = '0;
    exp_ovf = 1'b0;
    build_table();
    limit = rows.size() * 8 + 50;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    foreach (rows[i]) run_row(rows[i]);
    repeat (2) @(posedge clk);
    if (n_pass + n_fail != rows.size()) begin
      $display("checker saw %0d results for %0d operations", n_pass + n_fail, rows.size());
      hs_err++;
    end
    $display("done: %0d passed, %0d failed, %0d handshake errors, %0d assertion failures",
             n_pass, n_fail, hs_err, dut.u_props.err_cnt);
    if (n_fail == 0 && hs_err == 0 && dut.u_props.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- dp_top.sv
`timescale 1ns/10ps

module dp_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req,
  input  dp_pkg::reg_addr_t   raddr1,
  input  dp_pkg::reg_addr_t   raddr2,
  input  dp_pkg::reg_addr_t   waddr,
  input  logic         [4:0]  imm5,
  input  logic         [14:0] imm15,
  input  logic         [19:0] imm20,
  input  dp_pkg::imm_fmt_t    imm_fmt,
  input  logic                imm_sel,
  input  logic                wb_sel,
  input  dp_pkg::opcode_t     opcode,
  input  dp_pkg::sub_opcode_t sub_opcode,
  output logic                ack,
  output dp_pkg::word_t       result,
  output logic                overflow
);

  logic          fetch_en;
  logic          exec_en;
  logic          wb_en;
  dp_pkg::word_t rdata1;
  dp_pkg::word_t rdata2;
  dp_pkg::word_t imm;
  dp_pkg::word_t op2;
  dp_pkg::word_t src1_q;
  dp_pkg::word_t src2_q;
  dp_pkg::word_t alu_res;
  logic          alu_ovf;
  dp_pkg::word_t alu_res_q;
  logic          alu_ovf_q;
  dp_pkg::word_t wb_data;

  phase_ctrl u_phase (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .fetch_en (fetch_en),
    .exec_en  (exec_en),
    .wb_en    (wb_en)
  );

  regfile u_rf (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .waddr  (waddr),
    .wdata  (wb_data),
    .we     (wb_en),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  imm_ext u_imm (
    .imm5  (imm5),
    .imm15 (imm15),
    .imm20 (imm20),
    .fmt   (imm_fmt),
    .imm   (imm)
  );

  assign op2 = imm_sel ? imm : rdata2;

  // operand latch
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      src1_q <= rdata1;
      src2_q <= op2;
    end
  end

  alu32 u_alu (
    .src1       (src1_q),
    .src2       (src2_q),
    .opcode     (opcode),
    .sub_opcode (sub_opcode),
    .result     (alu_res),
    .overflow   (alu_ovf)
  );

  always_ff @(posedge clk) begin
    if (exec_en) begin
      alu_res_q <= alu_res;
      alu_ovf_q <= alu_ovf;
    end
  end

  // move bypasses the ALU
  assign wb_data = wb_sel ? src2_q : alu_res_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result   <= '0;
      overflow <= 1'b0;
    end else if (wb_en) begin
      result   <= wb_data;
      overflow <= !wb_sel && alu_ovf_q; // a move never overflows
    end
  end

endmodule

//--- imm_ext.sv
`timescale 1ns/10ps
`include "dp_defs.svh"

module imm_ext (
  input  logic             [4:0]  imm5,
  input  logic             [14:0] imm15,
  input  logic             [19:0] imm20,
  input  dp_pkg::imm_fmt_t        fmt,
  output dp_pkg::word_t           imm
);

  localparam int W = `DP_DATA_W;

  always_comb begin
    case (fmt)
      `IMM_ZE5: begin
        imm = {{(W-5){1'b0}}, imm5};
      end
      `IMM_SE15: begin
        imm = {{(W-15){imm15[14]}}, imm15};
      end
      `IMM_ZE15: begin
        imm = {{(W-15){1'b0}}, imm15};
      end
      `IMM_SE20: begin
        imm = {{(W-20){imm20[19]}}, imm20};
      end
      default: begin
        imm = '0; // unreachable with a 2-bit select
      end
    endcase
  end

endmodule

//--- phase_ctrl.sv
`timescale 1ns/10ps

module phase_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req,
  output logic ack,
  output logic fetch_en,
  output logic exec_en,
  output logic wb_en
);

  dp_pkg::phase_t state_q;
  dp_pkg::phase_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dp_pkg::PH_IDLE:  if (req) state_d = dp_pkg::PH_FETCH;
      dp_pkg::PH_FETCH: state_d = dp_pkg::PH_EXEC;
      dp_pkg::PH_EXEC:  state_d = dp_pkg::PH_WB;
      dp_pkg::PH_WB:    state_d = dp_pkg::PH_DONE;
      dp_pkg::PH_DONE:  if (!req) state_d = dp_pkg::PH_IDLE; // wait for req release
      default:          state_d = dp_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= dp_pkg::PH_IDLE;
      ack     <= 1'b0;
    end else begin
      state_q <= state_d;
      // rises one edge into PH_DONE, drops on the edge that sees req low
      ack     <= (state_q == dp_pkg::PH_DONE) && req;
    end
  end

  assign fetch_en = (state_q == dp_pkg::PH_FETCH);
  assign exec_en  = (state_q == dp_pkg::PH_EXEC);
  assign wb_en    = (state_q == dp_pkg::PH_WB);

endmodule

//--- regfile.sv
`timescale 1ns/10ps
`include "dp_defs.svh"

module regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  dp_pkg::reg_addr_t raddr1,
  input  dp_pkg::reg_addr_t raddr2,
  input  dp_pkg::reg_addr_t waddr,
  input  dp_pkg::word_t     wdata,
  input  logic              we,
  output dp_pkg::word_t     rdata1,
  output dp_pkg::word_t     rdata2
);

  localparam int NREGS = 2 ** `DP_ADDR_W;

  dp_pkg::word_t regs [NREGS];

  // r0 is an ordinary register here, not hardwired to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // async read, old value seen during a write cycle
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule
